/* sources.f */
+incdir+include
src/spi_msg_pkg.sv
src/sd_dat_pkg.sv
src/spi_frame_fsm.sv
src/spi_cmd_decoder.sv
src/sd_cmd6_capture.sv
src/spi_app_top.sv
tb/spi_app_assertions.sv
tb/spi_app_tb.sv

/* Makefile */
# Verilator simulation of the serial command link

VERILATOR ?= verilator
TOP       ?= spi_app_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv tb/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the simulator output
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/spi_app_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_app_params.svh"

module spi_app_tb;

    // ==================================================
    // Message types and run limits
    // ==================================================

    localparam logic [7:0] TYPE_ECHO      = 8'hC0;
    localparam logic [7:0] TYPE_LED_SET   = 8'h81;
    localparam logic [7:0] TYPE_SD_STATUS = 8'hC2;
    localparam logic [7:0] TYPE_NOP       = 8'h80;
    localparam logic [7:0] TYPE_UNKNOWN   = 8'h9A;  // Start bit set, no response flag

    localparam int NUM_ROWS    = 13;
    localparam int CYCLE_LIMIT = NUM_ROWS * 200 + 100;

    typedef struct {
        bit                      is_block;     // SD block instead of a frame
        logic [7:0]              msg_type;
        logic [`MSG_ARG_LEN-1:0] arg;          // Nibble in [3:0] for blocks
        bit                      gaps;         // Idle cycles between triggers
        int                      abort_words;  // Words before a mid-block restart
        bit                      has_resp;
        logic [3:0]              exp_led;
        logic [`RESP_LEN-1:0]    exp_resp;
    } row_t;

    row_t       rows [NUM_ROWS];
    int         row_count;
    int         cycle_count = 0;
    logic [3:0] cur_led;    // LED state predicted while building the table
    logic [3:0] cur_mode;   // Access mode of the last SD block

    logic        sd_datInWrite_clk;
    logic        spi_rst_;
    logic        spi_data_in;
    logic        spi_data_out;
    logic        spi_data_out_en;
    logic [3:0]  ice_led;
    logic        sd_datInWrite_rst;
    logic        sd_datInWrite_trigger;
    logic [15:0] sd_datInWrite_data;

    spi_app_top spi_app_top_i (
        .sd_datInWrite_clk     (sd_datInWrite_clk),
        .spi_rst_              (spi_rst_),
        .spi_data_in           (spi_data_in),
        .spi_data_out          (spi_data_out),
        .spi_data_out_en       (spi_data_out_en),
        .ice_led               (ice_led),
        .sd_datInWrite_rst     (sd_datInWrite_rst),
        .sd_datInWrite_trigger (sd_datInWrite_trigger),
        .sd_datInWrite_data    (sd_datInWrite_data)
    );

    always #2 sd_datInWrite_clk = ~sd_datInWrite_clk;

    always @(posedge sd_datInWrite_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_now($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    // ==================================================
    // Reporting
    // ==================================================

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED time %0d ns: %s got %h expected %h",
                     $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "Simulation stopped");
        end
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================

    function automatic logic [`MSG_ARG_LEN-1:0] random_arg();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[`MSG_ARG_LEN-1:0];
    endfunction

    // Random upper bits above a chosen LED value
    function automatic logic [`MSG_ARG_LEN-1:0] led_arg(input logic [3:0] led);
        logic [`MSG_ARG_LEN-1:0] a;
        a = random_arg();
        a[3:0] = led;
        return a;
    endfunction

    task automatic add_frame_row(input logic [7:0] t, input logic [`MSG_ARG_LEN-1:0] a);
        row_t r;
        r.is_block    = 1'b0;
        r.msg_type    = t;
        r.arg         = a;
        r.gaps        = 1'b0;
        r.abort_words = 0;
        r.has_resp    = t[6];  // Response flag in the type field
        if (t == TYPE_LED_SET) begin
            cur_led = a[3:0];
        end
        r.exp_led = cur_led;
        case (t)
            TYPE_ECHO:      r.exp_resp = {a, 8'h00};
            TYPE_SD_STATUS: r.exp_resp = {cur_mode, 60'h0};
            default:        r.exp_resp = '0;
        endcase
        rows[row_count] = r;
        row_count++;
    endtask

    task automatic add_block_row(input logic [3:0] nibble, input bit gaps, input int abort_words);
        row_t r;
        r.is_block    = 1'b1;
        r.msg_type    = 8'h00;
        r.arg         = {52'h0, nibble};
        r.gaps        = gaps;
        r.abort_words = abort_words;
        r.has_resp    = 1'b0;
        r.exp_led     = cur_led;
        r.exp_resp    = '0;
        cur_mode      = nibble;
        rows[row_count] = r;
        row_count++;
    endtask

    // ==================================================
    // Serial link and SD stream drivers
    // ==================================================

    task automatic send_frame(input logic [`MSG_LEN-1:0] m);
        int i;
        for (i = `MSG_LEN - 1; i >= 0; i--) begin
            @(negedge sd_datInWrite_clk);
            spi_data_in = m[i];
        end
        @(negedge sd_datInWrite_clk);
        spi_data_in = 1'b0;  // Line idle from here
    endtask

    task automatic collect_response(output logic [`RESP_LEN-1:0] got);
        int waited;
        int i;
        waited = 0;
        got = '0;
        while (!spi_data_out_en && waited < `TURNAROUND_CYCLES + 16) begin
            @(negedge sd_datInWrite_clk);
            waited++;
        end
        if (!spi_data_out_en) begin
            fail_now("No response window opened after a frame that asks for one");
        end else begin
            check_value("turnaround cycles", 64'(waited), 64'(`TURNAROUND_CYCLES));
            for (i = `RESP_LEN - 1; i >= 0; i--) begin
                check_value("spi_data_out_en", {63'h0, spi_data_out_en}, 64'h1);
                got[i] = spi_data_out;
                @(negedge sd_datInWrite_clk);
            end
            check_value("spi_data_out_en", {63'h0, spi_data_out_en}, 64'h0);
        end
    endtask

    task automatic watch_no_response();
        int i;
        for (i = 0; i < `TURNAROUND_CYCLES + 2; i++) begin
            check_value("spi_data_out_en", {63'h0, spi_data_out_en}, 64'h0);
            @(negedge sd_datInWrite_clk);
        end
    endtask

    // Non-mode words carry the inverted nibble so a wrong capture shows up
    function automatic logic [15:0] build_word(input int index, input logic [3:0] nibble);
        logic [31:0] r;
        logic [15:0] w;
        r = $urandom;
        w = r[15:0];
        w[`CMD6_MODE_LSB +: 4] = (index == `CMD6_MODE_WORD) ? nibble : ~nibble;
        return w;
    endfunction

    task automatic send_sd_block(input logic [3:0] nibble, input bit gaps, input int abort_words);
        int i;
        int g;
        @(negedge sd_datInWrite_clk);
        sd_datInWrite_rst = 1'b1;
        @(negedge sd_datInWrite_clk);
        sd_datInWrite_rst = 1'b0;
        if (abort_words > 0) begin
            for (i = 0; i < abort_words; i++) begin
                @(negedge sd_datInWrite_clk);
                sd_datInWrite_trigger = 1'b1;
                sd_datInWrite_data    = build_word(i, nibble);
            end
            @(negedge sd_datInWrite_clk);
            sd_datInWrite_trigger = 1'b0;
            sd_datInWrite_rst     = 1'b1;  // Restart mid-block
            @(negedge sd_datInWrite_clk);
            sd_datInWrite_rst     = 1'b0;
        end
        for (i = 0; i < `SD_BLOCK_WORDS; i++) begin
            if (gaps) begin
                g = $urandom % 4;
                repeat (g) begin
                    @(negedge sd_datInWrite_clk);
                    sd_datInWrite_trigger = 1'b0;
                end
            end
            @(negedge sd_datInWrite_clk);
            sd_datInWrite_trigger = 1'b1;
            sd_datInWrite_data    = build_word(i, nibble);
        end
        @(negedge sd_datInWrite_clk);
        sd_datInWrite_trigger = 1'b0;
        sd_datInWrite_data    = '0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int i;
        logic [`RESP_LEN-1:0] got;
        sd_datInWrite_clk     = 1'b0;
        spi_rst_              = 1'b0;
        spi_data_in           = 1'b0;
        sd_datInWrite_rst     = 1'b0;
        sd_datInWrite_trigger = 1'b0;
        sd_datInWrite_data    = '0;
        void'($urandom(32'h397d));

        row_count = 0;
        cur_led   = 4'h0;
        cur_mode  = 4'h0;
        add_frame_row(TYPE_SD_STATUS, '0);          // Reset state
        add_frame_row(TYPE_ECHO, random_arg());
        add_frame_row(TYPE_LED_SET, led_arg(4'hA));
        add_frame_row(TYPE_LED_SET, led_arg(4'h5));
        add_frame_row(TYPE_LED_SET, led_arg(4'h3));
        add_block_row(4'h9, 1'b0, 0);
        add_frame_row(TYPE_SD_STATUS, random_arg());
        add_block_row(4'h6, 1'b1, 5);               // Gaps and a mid-block restart
        add_frame_row(TYPE_SD_STATUS, '0);
        add_frame_row(TYPE_NOP, led_arg(4'hC));
        add_frame_row(TYPE_UNKNOWN, led_arg(4'hE));
        add_frame_row(TYPE_ECHO, random_arg());
        add_frame_row(TYPE_SD_STATUS, '0);

        repeat (5) @(negedge sd_datInWrite_clk);
        spi_rst_ = 1'b1;
        @(negedge sd_datInWrite_clk);
        check_value("ice_led", {60'h0, ice_led}, 64'h0);
        check_value("spi_data_out_en", {63'h0, spi_data_out_en}, 64'h0);

        for (i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].is_block) begin
                send_sd_block(rows[i].arg[3:0], rows[i].gaps, rows[i].abort_words);
            end else begin
                send_frame({rows[i].msg_type, rows[i].arg});
                if (rows[i].has_resp) begin
                    collect_response(got);
                    check_value("spi_data_out response", got, rows[i].exp_resp);
                end else begin
                    watch_no_response();
                end
                check_value("ice_led", {60'h0, ice_led}, {60'h0, rows[i].exp_led});
            end
        end

        if (spi_app_top_i.spi_app_assertions_i.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_now($sformatf("Bound assertions failed %0d times",
                               spi_app_top_i.spi_app_assertions_i.fail_count));
        end
    end

endmodule

`default_nettype wire

/* tb/spi_app_assertions.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_app_params.svh"

module spi_app_assertions import sd_dat_pkg::*; (
    input logic         sd_datInWrite_clk,
    input logic         spi_rst_,
    input logic         spi_data_out_en,
    input logic         sd_datInWrite_rst,
    input logic         sd_datInWrite_trigger,
    input access_mode_t access_mode
);

    int en_run;          // Consecutive cycles with the enable high
    int fail_count = 0;  // Assertion failures so far

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            en_run <= 0;
        end else if (spi_data_out_en) begin
            en_run <= en_run + 1;
        end else begin
            en_run <= 0;
        end
    end

    // ==================================================
    // Link and capture properties
    // ==================================================

    en_low_in_reset: assert property (@(posedge sd_datInWrite_clk)
        !spi_rst_ |-> !spi_data_out_en)
        else begin
            fail_count = fail_count + 1;
            $error("spi_data_out_en high during reset");
        end

    // Window never longer than one response
    en_window_max: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        spi_data_out_en |-> (en_run < `RESP_LEN))
        else begin
            fail_count = fail_count + 1;
            $error("spi_data_out_en high for more than one response length");
        end

    mode_after_word: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        !$stable(access_mode) |-> $past(sd_datInWrite_trigger && !sd_datInWrite_rst))
        else begin
            fail_count = fail_count + 1;
            $error("access_mode changed without an accepted data-in word");
        end

endmodule

bind spi_app_top spi_app_assertions spi_app_assertions_i (
    .sd_datInWrite_clk     (sd_datInWrite_clk),
    .spi_rst_              (spi_rst_),
    .spi_data_out_en       (spi_data_out_en),
    .sd_datInWrite_rst     (sd_datInWrite_rst),
    .sd_datInWrite_trigger (sd_datInWrite_trigger),
    .access_mode           (access_mode)
);

`default_nettype wire

/* src/spi_app_top.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_app_top import spi_msg_pkg::*, sd_dat_pkg::*; (
    input  logic       sd_datInWrite_clk,
    input  logic       spi_rst_,

    // One-wire serial link
    input  logic       spi_data_in,
    output logic       spi_data_out,
    output logic       spi_data_out_en,

    output logic [3:0] ice_led,

    // SD data-in write stream
    input  logic       sd_datInWrite_rst,
    input  logic       sd_datInWrite_trigger,
    input  sd_word_t   sd_datInWrite_data
);

    msg_t         msg;
    logic         msg_valid;
    resp_t        resp;
    access_mode_t access_mode;

    // ==================================================
    // Serial framing
    // ==================================================

    spi_frame_fsm spi_frame_fsm_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_data_in       (spi_data_in),
        .resp              (resp),
        .msg               (msg),
        .msg_valid         (msg_valid),
        .spi_data_out      (spi_data_out),
        .spi_data_out_en   (spi_data_out_en)
    );

    // ==================================================
    // Command handling
    // ==================================================

    spi_cmd_decoder spi_cmd_decoder_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .msg               (msg),
        .msg_valid         (msg_valid),
        .access_mode       (access_mode),
        .resp              (resp),
        .ice_led           (ice_led)
    );

    // CMD6 status block monitor
    sd_cmd6_capture sd_cmd6_capture_i (
        .sd_datInWrite_clk     (sd_datInWrite_clk),
        .spi_rst_              (spi_rst_),
        .sd_datInWrite_rst     (sd_datInWrite_rst),
        .sd_datInWrite_trigger (sd_datInWrite_trigger),
        .sd_datInWrite_data    (sd_datInWrite_data),
        .access_mode           (access_mode)
    );

endmodule

`default_nettype wire

/* src/sd_cmd6_capture.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_app_params.svh"

module sd_cmd6_capture import sd_dat_pkg::*; (
    input  logic         sd_datInWrite_clk,
    input  logic         spi_rst_,
    input  logic         sd_datInWrite_rst,
    input  logic         sd_datInWrite_trigger,
    input  sd_word_t     sd_datInWrite_data,
    output access_mode_t access_mode
);

    // Countdown value while the access-mode word is on the bus
    localparam word_count_t MODE_COUNT =
        word_count_t'(`SD_BLOCK_WORDS - 1 - `CMD6_MODE_WORD);

    word_count_t word_cnt;

    // ==================================================
    // Word counter and access-mode latch
    // ==================================================

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_cnt    <= word_count_t'(`SD_BLOCK_WORDS - 1);
            access_mode <= '0;
        end else if (sd_datInWrite_rst) begin
            word_cnt <= word_count_t'(`SD_BLOCK_WORDS - 1);  // New block
        end else if (sd_datInWrite_trigger) begin
            // Always ready, so every trigger is an accepted word
            word_cnt <= word_cnt - 1'b1;
            if (word_cnt == MODE_COUNT) begin
                access_mode <= sd_datInWrite_data[`CMD6_MODE_LSB +: $bits(access_mode_t)];
            end
        end
    end

endmodule

`default_nettype wire

/* src/spi_cmd_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_app_params.svh"

module spi_cmd_decoder import spi_msg_pkg::*, sd_dat_pkg::*; (
    input  logic         sd_datInWrite_clk,
    input  logic         spi_rst_,
    input  msg_t         msg,
    input  logic         msg_valid,
    input  access_mode_t access_mode,
    output resp_t        resp,
    output logic [3:0]   ice_led
);

    // ==================================================
    // Response layouts
    // ==================================================

    // Echo pads the low byte with zeros
    localparam int ECHO_PAD = `RESP_LEN - `MSG_ARG_LEN;

    // SDStatus puts the access mode at the very top
    localparam int STATUS_PAD = `RESP_LEN - $bits(access_mode_t);

    resp_t echo_resp;
    resp_t status_resp;

    assign echo_resp   = {msg.arg.echo, {ECHO_PAD{1'b0}}};
    assign status_resp = {access_mode, {STATUS_PAD{1'b0}}};

    // ==================================================
    // Command decode
    // ==================================================

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            resp    <= '0;
            ice_led <= '0;
        end else if (msg_valid) begin
            case (msg.msg_type)
                MSG_ECHO: begin
                    resp <= echo_resp;
                end

                MSG_LED_SET: begin
                    ice_led <= msg.arg.led_set.led;  // No response window follows
                end

                MSG_SD_STATUS: begin
                    resp <= status_resp;
                end

                default: begin
                    // Nop and unrecognized types leave LEDs and resp alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/spi_frame_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

`include "spi_app_params.svh"

module spi_frame_fsm import spi_msg_pkg::*; (
    input  logic  sd_datInWrite_clk,
    input  logic  spi_rst_,
    input  logic  spi_data_in,
    input  resp_t resp,
    output msg_t  msg,
    output logic  msg_valid,
    output logic  spi_data_out,
    output logic  spi_data_out_en
);

    // ==================================================
    // State and counters
    // ==================================================

    localparam logic [1:0] ST_IDLE = 2'd0;  // Waiting for start bit
    localparam logic [1:0] ST_RECV = 2'd1;
    localparam logic [1:0] ST_TURN = 2'd2;  // Turnaround, line released
    localparam logic [1:0] ST_RESP = 2'd3;

    localparam int RESP_FLAG_BIT = 6;
    localparam int CNT_MAX = (`MSG_LEN > `RESP_LEN) ? `MSG_LEN : `RESP_LEN;
    localparam int CNT_W = $clog2(CNT_MAX);

    logic [1:0]       state;
    logic [CNT_W-1:0] cnt;      // Bits left, or turnaround cycles left
    msg_t             msg_sr;
    resp_t            resp_sr;

    assign msg = msg_sr;
    assign spi_data_out = resp_sr[`RESP_LEN-1];

    // ==================================================
    // Frame sequencing
    // ==================================================

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state           <= ST_IDLE;
            cnt             <= '0;
            msg_valid       <= 1'b0;
            spi_data_out_en <= 1'b0;
            resp_sr         <= '0;
        end else begin
            msg_valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    // First high bit is type bit 7, so it belongs to the message
                    if (spi_data_in) begin
                        cnt   <= CNT_W'(`MSG_LEN - 2);
                        state <= ST_RECV;
                    end
                end

                ST_RECV: begin
                    if (cnt == '0) begin
                        // Last message bit sampled on this edge
                        cnt   <= CNT_W'(`TURNAROUND_CYCLES - 1);
                        state <= ST_TURN;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                ST_TURN: begin
                    cnt <= cnt - 1'b1;

                    // Two cycles after the last bit
                    if (cnt == CNT_W'(`TURNAROUND_CYCLES - 2)) begin
                        msg_valid <= 1'b1;
                    end

                    if (cnt == '0) begin
                        if (msg_sr.msg_type[RESP_FLAG_BIT]) begin
                            resp_sr         <= resp;     // Settled since msg_valid
                            cnt             <= CNT_W'(`RESP_LEN - 1);
                            spi_data_out_en <= 1'b1;
                            state           <= ST_RESP;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end

                ST_RESP: begin
                    resp_sr <= {resp_sr[`RESP_LEN-2:0], 1'b0};
                    cnt     <= cnt - 1'b1;
                    if (cnt == '0) begin
                        spi_data_out_en <= 1'b0;  // Exactly RESP_LEN cycles high
                        state           <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==================================================
    // Message shift register
    // ==================================================

    // Shifts from the start bit through the last message bit
    always_ff @(posedge sd_datInWrite_clk) begin
        if ((state == ST_RECV) || ((state == ST_IDLE) && spi_data_in)) begin
            msg_sr <= msg_t'({msg_sr[`MSG_LEN-2:0], spi_data_in});
        end
    end

endmodule

`default_nettype wire

/* src/sd_dat_pkg.sv */
`default_nettype none

`include "spi_app_params.svh"

package sd_dat_pkg;

    // One word of the SD data-in write stream
    typedef logic [15:0] sd_word_t;

    // CMD6 access-mode field
    typedef logic [3:0] access_mode_t;

    // Counts down across one data block
    typedef logic [$clog2(`SD_BLOCK_WORDS)-1:0] word_count_t;

endpackage

`default_nettype wire

/* src/spi_msg_pkg.sv */
`default_nettype none

`include "spi_app_params.svh"

package spi_msg_pkg;

    // ==================================================
    // Message type field
    // ==================================================

    // Bit 7 marks the frame start, bit 6 requests a response
    typedef enum logic [`MSG_TYPE_LEN-1:0] {
        MSG_ECHO      = 8'hC0,
        MSG_LED_SET   = 8'h81,
        MSG_SD_STATUS = 8'hC2,
        MSG_NOP       = 8'h80
    } msg_type_t;

    // ==================================================
    // Message argument, decoded per type
    // ==================================================

    typedef struct packed {
        logic [`MSG_ARG_LEN-5:0] unused;
        logic [3:0]              led;     // Value for ice_led
    } led_set_arg_t;

    typedef union packed {
        logic [`MSG_ARG_LEN-1:0] echo;    // Whole payload returned
        led_set_arg_t            led_set;
    } msg_arg_t;

    // Full message as shifted in
    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_t  arg;
    } msg_t;

    // Response word, shifted out MSB first
    typedef logic [`RESP_LEN-1:0] resp_t;

endpackage

`default_nettype wire

/* include/spi_app_params.svh */
`ifndef SPI_APP_PARAMS_SVH
`define SPI_APP_PARAMS_SVH

// ==================================================
// Serial link framing
// ==================================================

// Bits per incoming message, MSB first
`define MSG_LEN 64

// Type field sits at the top of the message
`define MSG_TYPE_LEN 8

// Argument below the type field
`define MSG_ARG_LEN 56

// Bits per outgoing response
`define RESP_LEN 64

// Quiet cycles between last message bit and first response bit
`define TURNAROUND_CYCLES 8

// ==================================================
// SD CMD6 data block layout
// ==================================================

`define SD_BLOCK_WORDS 32   // 512-bit block as 16-bit words
`define CMD6_MODE_WORD 8    // Word index from block start
`define CMD6_MODE_LSB 8     // Access-mode nibble position

`endif
